// ==== dma_wb_top.f ====
common/dma_pkg.sv
src/dma_word_fifo.sv
dma/dma_cfg_wb.sv
dma/dma_request_table.sv
dma/dma_reader.sv
dma/dma_writer.sv
dma/dma_bus_arb.sv
dma/dma_wb_top.sv
sim/tb_clkgen.sv
sim/tb_wb_mem.sv
sim/tb_dma.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= tb_dma
FILELIST  ?= dma_wb_top.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_dma.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dma;

  import dma_pkg::*;

  localparam int          WORDS    = 1024;  // 4 KB of memory
  localparam int unsigned TIMEOUT  = 2000;  // Cycles per wait
  localparam int          NUM_JOBS = 8;

  typedef struct packed {
    logic [POS_W-1:0]  entry;
    logic [ADDR_W-1:0] src;
    logic [ADDR_W-1:0] dst;
    logic [LEN_W-1:0]  len;
    logic              queue;  // Goes together with the next row
  } job_row_t;

  // Sources stay below 0x800 and are never written
  localparam job_row_t JOBS [NUM_JOBS] = '{
    '{2'd0, 32'h0000_0000, 32'h0000_0800, 16'd1,  1'b0},
    '{2'd1, 32'h0000_0040, 32'h0000_0880, 16'd5,  1'b0},
    '{2'd2, 32'h0000_0100, 32'h0000_0900, 16'd12, 1'b0},
    '{2'd3, 32'h0000_0200, 32'h0000_0a00, 16'd0,  1'b0},
    '{2'd0, 32'h0000_0080, 32'h0000_0b00, 16'd7,  1'b1},
    '{2'd1, 32'h0000_0300, 32'h0000_0c00, 16'd4,  1'b1},
    '{2'd2, 32'h0000_03c0, 32'h0000_0d00, 16'd9,  1'b0},
    '{2'd3, 32'h0000_0010, 32'h0000_0e00, 16'd3,  1'b0}
  };

  logic               clk;
  logic               rst;
  wb_m2s_t            cfg_m2s;
  wb_s2m_t            cfg_s2m;
  wb_m2s_t            mem_m2s;
  wb_s2m_t            mem_s2m;
  logic [ENTRIES-1:0] irq;

  logic [DATA_W-1:0] exp_mem [WORDS];  // Expected memory image
  int                group_q [$];      // Rows waiting for a common go
  int unsigned       errors = 0;
  int unsigned       checks = 0;

  tb_clkgen #(.PERIOD_NS(20), .RESET_CYCLES(2)) clkgen_inst (.clk_o(clk), .rst_o(rst));

  dma_wb_top dma_wb_top_inst (
    .clk, .rst,
    .cfg_m2s_i(cfg_m2s), .cfg_s2m_o(cfg_s2m),
    .mem_m2s_o(mem_m2s), .mem_s2m_i(mem_s2m),
    .irq_o(irq)
  );

  tb_wb_mem #(.WORDS(WORDS)) mem_inst (.clk, .rst, .m2s_i(mem_m2s), .s2m_o(mem_s2m));

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // One Wishbone access on the configuration port
  task automatic cfg_access(input logic we, input logic [ADDR_W-1:0] adr,
                            input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
    int unsigned n;
    logic        seen;
    n    = 0;
    seen = 1'b0;
    rdat = '0;
    @(posedge clk);
    #1;
    cfg_m2s.adr = adr;
    cfg_m2s.dat = wdat;
    cfg_m2s.sel = '1;
    cfg_m2s.we  = we;
    cfg_m2s.cyc = 1'b1;
    cfg_m2s.stb = 1'b1;
    while (!seen && n < TIMEOUT) begin
      @(negedge clk);
      n++;
      if (cfg_s2m.ack) begin
        seen = 1'b1;
        rdat = cfg_s2m.dat;
      end
    end
    assert (seen) else begin
      errors++;
      $display("Timeout: configuration access to %h was never acknowledged", adr);
    end
    @(posedge clk);  // Write lands on this edge
    #1;
    cfg_m2s = '0;
  endtask

  task automatic reg_write(input logic [POS_W-1:0] entry, input logic [1:0] word,
                           input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] unused;
    cfg_access(1'b1, ADDR_W'({entry, word, 2'b00}), data, unused);
  endtask

  task automatic reg_read(input logic [POS_W-1:0] entry, input logic [1:0] word,
                          output logic [DATA_W-1:0] data);
    cfg_access(1'b0, ADDR_W'({entry, word, 2'b00}), '0, data);
  endtask

  task automatic wait_irq(input logic [ENTRIES-1:0] mask);
    int unsigned n;
    logic        seen;
    n    = 0;
    seen = ((irq & mask) == mask);
    while (!seen && n < TIMEOUT) begin
      @(negedge clk);
      n++;
      seen = ((irq & mask) == mask);
    end
    assert (seen) else begin
      errors++;
      $display("Timeout: interrupts %b did not all rise", mask);
    end
  endtask

  task automatic program_entry(input job_row_t row);
    logic [DATA_W-1:0] rdat;
    reg_write(row.entry, REG_SRC, row.src);
    reg_write(row.entry, REG_DST, row.dst);
    reg_write(row.entry, REG_LEN, DATA_W'(row.len));
    reg_read(row.entry, REG_SRC, rdat);
    check_value("src readback", rdat, row.src);
    reg_read(row.entry, REG_DST, rdat);
    check_value("dst readback", rdat, row.dst);
    reg_read(row.entry, REG_LEN, rdat);
    check_value("len readback", rdat, DATA_W'(row.len));
  endtask

  task automatic compare_memory();
    for (int i = 0; i < WORDS; i++) begin
      check_value($sformatf("mem[%0d]", i), mem_inst.peek_word(i), exp_mem[i]);
    end
  endtask

  // Go for every queued row, then wait, check and acknowledge
  task automatic run_group();
    job_row_t           row;
    logic [ENTRIES-1:0] mask;
    logic [DATA_W-1:0]  rdat;
    int unsigned        writes_before;
    int unsigned        total_len;
    mask          = '0;
    total_len     = 0;
    writes_before = mem_inst.write_count;
    foreach (group_q[i]) begin
      row = JOBS[group_q[i]];
      reg_write(row.entry, REG_CTRL, DATA_W'(1) << CTRL_GO_BIT);
      reg_read(row.entry, REG_CTRL, rdat);
      check_value("ctrl valid/done after go", {30'd0, rdat[1:0]}, 32'h1);
      mask[row.entry] = 1'b1;
      total_len += row.len;
      for (int k = 0; k < row.len; k++) begin
        exp_mem[int'(row.dst >> 2) + k] = exp_mem[int'(row.src >> 2) + k];
      end
    end
    wait_irq(mask);
    check_value("irq_o", 32'(irq), 32'(mask));
    foreach (group_q[i]) begin
      reg_read(JOBS[group_q[i]].entry, REG_CTRL, rdat);
      check_value("ctrl after completion", rdat, 32'h2);  // Done only
    end
    check_value("memory writes", mem_inst.write_count - writes_before, total_len);
    compare_memory();
    foreach (group_q[i]) begin
      row = JOBS[group_q[i]];
      reg_write(row.entry, REG_CTRL, DATA_W'(1) << CTRL_ACK_BIT);
      mask[row.entry] = 1'b0;
      check_value("irq_o after ack", 32'(irq), 32'(mask));
      reg_read(row.entry, REG_CTRL, rdat);
      check_value("ctrl after ack", rdat, 32'h0);
    end
    group_q.delete();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    logic [DATA_W-1:0] rdat;
    logic [DATA_W-1:0] word;
    int unsigned       n;
    void'($urandom(32'hf49f));
    cfg_m2s = '0;
    for (int i = 0; i < WORDS; i++) begin
      word       = $urandom;
      exp_mem[i] = word;
      mem_inst.load_word(i, word);
    end
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (rst && n < TIMEOUT);
    assert (!rst) else begin
      errors++;
      $display("Timeout: reset was never released");
    end
    @(negedge clk);
    check_value("irq_o after reset", 32'(irq), 32'h0);
    check_value("mem cyc after reset", 32'(mem_m2s.cyc), 32'h0);
    for (int e = 0; e < ENTRIES; e++) begin
      reg_read(POS_W'(e), REG_CTRL, rdat);
      check_value("ctrl after reset", rdat, 32'h0);
    end
    for (int r = 0; r < NUM_JOBS; r++) begin
      program_entry(JOBS[r]);
      group_q.push_back(r);
      if (!JOBS[r].queue) run_group();
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tb_wb_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_wb_mem #(
  parameter int WORDS = 1024
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire  dma_pkg::wb_m2s_t  m2s_i,
  output dma_pkg::wb_s2m_t        s2m_o
);

  import dma_pkg::*;

  localparam int IDX_W = $clog2(WORDS);

  logic [DATA_W-1:0] mem [WORDS];
  logic [1:0]        wait_q;       // Wait cycles left before the next ack
  logic [IDX_W-1:0]  idx;
  int unsigned       write_count;  // Acked writes since time zero

  assign idx = m2s_i.adr[IDX_W+1:2];

  initial write_count = 0;

  always @(posedge clk) begin
    if (rst) begin
      s2m_o  <= '0;
      wait_q <= 2'($urandom);
    end else if (s2m_o.ack) begin
      s2m_o.ack <= 1'b0;  // Single-cycle ack
      wait_q    <= 2'($urandom);
    end else if (m2s_i.cyc && m2s_i.stb) begin
      if (wait_q == '0) begin
        s2m_o.ack <= 1'b1;
        if (m2s_i.we) begin
          for (int b = 0; b < DATA_W / 8; b++) begin
            if (m2s_i.sel[b]) mem[idx][8*b +: 8] <= m2s_i.dat[8*b +: 8];
          end
          write_count <= write_count + 1;
        end else begin
          s2m_o.dat <= mem[idx];
        end
      end else begin
        wait_q <= wait_q - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Backdoor

  task automatic load_word(input int unsigned i, input logic [DATA_W-1:0] d);
    mem[i] = d;
  endtask

  function automatic logic [DATA_W-1:0] peek_word(input int unsigned i);
    return mem[i];
  endfunction

endmodule

`default_nettype wire

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Released just after an edge, like every other input
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== dma/dma_wb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_wb_top (
  input  wire                          clk,
  input  wire                          rst,
  input  wire  dma_pkg::wb_m2s_t       cfg_m2s_i,
  output dma_pkg::wb_s2m_t             cfg_s2m_o,
  output dma_pkg::wb_m2s_t             mem_m2s_o,
  input  wire  dma_pkg::wb_s2m_t       mem_s2m_i,
  output logic [dma_pkg::ENTRIES-1:0]  irq_o
);

  import dma_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect

  // Configuration slave to table
  logic              wr_en;
  logic [POS_W-1:0]  wr_pos;       // Also the read entry
  logic [1:0]        wr_sel;
  logic [DATA_W-1:0] wr_data;
  logic              go_en;
  logic [POS_W-1:0]  go_pos;
  logic              ack_en;
  logic [POS_W-1:0]  ack_pos;
  dma_req_t          rd_req;
  logic [2:0]        rd_state;

  // Table and reader
  logic [POS_W-1:0]   sel_pos;
  dma_req_t           sel_req;
  logic [ENTRIES-1:0] pending;
  logic               claim_en;

  // Job handoff and completion
  logic             job_en;
  dma_req_t         job;
  logic [POS_W-1:0] job_pos;
  logic             writer_busy;
  logic             done_en;
  logic [POS_W-1:0] done_pos;

  // Data path through the FIFO
  logic              push;
  logic [DATA_W-1:0] push_data;
  logic              pop;
  logic [DATA_W-1:0] pop_data;
  logic              fifo_full;
  logic              fifo_empty;

  wb_m2s_t rd_m2s;
  wb_s2m_t rd_s2m;
  wb_m2s_t wr_m2s;
  wb_s2m_t wr_s2m;

  ////////////////////////////////////////////////////////////////////////////
  // Blocks

  dma_cfg_wb cfg_wb_inst (
    .clk, .rst, .cfg_m2s_i, .cfg_s2m_o,
    .wr_en_o(wr_en), .wr_pos_o(wr_pos), .wr_sel_o(wr_sel), .wr_data_o(wr_data),
    .go_en_o(go_en), .go_pos_o(go_pos), .ack_en_o(ack_en), .ack_pos_o(ack_pos),
    .rd_req_i(rd_req), .rd_state_i(rd_state)
  );

  dma_request_table request_table_inst (
    .clk, .rst,
    .wr_en_i(wr_en), .wr_pos_i(wr_pos), .wr_sel_i(wr_sel), .wr_data_i(wr_data),
    .go_en_i(go_en), .go_pos_i(go_pos), .ack_en_i(ack_en), .ack_pos_i(ack_pos),
    .rd_pos_i(wr_pos), .rd_req_o(rd_req), .rd_state_o(rd_state),
    .sel_pos_i(sel_pos), .sel_req_o(sel_req), .pending_o(pending),
    .claim_en_i(claim_en), .done_en_i(done_en), .done_pos_i(done_pos),
    .irq_o
  );

  dma_reader reader_inst (
    .clk, .rst,
    .pending_i(pending), .sel_pos_o(sel_pos), .sel_req_i(sel_req),
    .claim_en_o(claim_en), .writer_busy_i(writer_busy),
    .job_en_o(job_en), .job_o(job), .job_pos_o(job_pos),
    .fifo_full_i(fifo_full), .push_o(push), .push_data_o(push_data),
    .m2s_o(rd_m2s), .s2m_i(rd_s2m)
  );

  dma_word_fifo word_fifo_inst (
    .clk, .rst,
    .push_i(push), .push_data_i(push_data), .pop_i(pop), .pop_data_o(pop_data),
    .full_o(fifo_full), .empty_o(fifo_empty)
  );

  dma_writer writer_inst (
    .clk, .rst,
    .job_en_i(job_en), .job_i(job), .job_pos_i(job_pos), .busy_o(writer_busy),
    .fifo_empty_i(fifo_empty), .pop_o(pop), .pop_data_i(pop_data),
    .done_en_o(done_en), .done_pos_o(done_pos),
    .m2s_o(wr_m2s), .s2m_i(wr_s2m)
  );

  dma_bus_arb bus_arb_inst (
    .clk, .rst,
    .rd_m2s_i(rd_m2s), .rd_s2m_o(rd_s2m), .wr_m2s_i(wr_m2s), .wr_s2m_o(wr_s2m),
    .mem_m2s_o, .mem_s2m_i
  );

endmodule

`default_nettype wire

// ==== dma/dma_bus_arb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_bus_arb (
  input  wire                     clk,
  input  wire                     rst,
  input  wire  dma_pkg::wb_m2s_t  rd_m2s_i,
  output dma_pkg::wb_s2m_t        rd_s2m_o,
  input  wire  dma_pkg::wb_m2s_t  wr_m2s_i,
  output dma_pkg::wb_s2m_t        wr_s2m_o,
  output dma_pkg::wb_m2s_t        mem_m2s_o,
  input  wire  dma_pkg::wb_s2m_t  mem_s2m_i
);

  logic owner_wr_q;    // 1 writer, 0 reader
  logic owner_wr_d;
  logic owner_active;

  assign owner_active = owner_wr_q ? wr_m2s_i.cyc : rd_m2s_i.cyc;

  // Grant sticks while the owner holds cyc, writer first otherwise
  always_comb begin
    if (owner_active) begin
      owner_wr_d = owner_wr_q;
    end else if (wr_m2s_i.cyc) begin
      owner_wr_d = 1'b1;
    end else begin
      owner_wr_d = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      owner_wr_q <= 1'b0;
    end else begin
      owner_wr_q <= owner_wr_d;
    end
  end

  // Non-owner sees an idle slave
  always_comb begin
    rd_s2m_o = '0;
    wr_s2m_o = '0;
    if (owner_wr_q) begin
      mem_m2s_o = wr_m2s_i;
      wr_s2m_o  = mem_s2m_i;
    end else begin
      mem_m2s_o = rd_m2s_i;
      rd_s2m_o  = mem_s2m_i;
    end
  end

endmodule

`default_nettype wire

// ==== dma/dma_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_writer (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          job_en_i,
  input  wire  dma_pkg::dma_req_t      job_i,
  input  wire  [dma_pkg::POS_W-1:0]    job_pos_i,
  output logic                         busy_o,
  input  wire                          fifo_empty_i,
  output logic                         pop_o,
  input  wire  [dma_pkg::DATA_W-1:0]   pop_data_i,
  output logic                         done_en_o,
  output logic [dma_pkg::POS_W-1:0]    done_pos_o,
  output dma_pkg::wb_m2s_t             m2s_o,
  input  wire  dma_pkg::wb_s2m_t       s2m_i
);

  import dma_pkg::*;

  logic              busy_q;
  logic [POS_W-1:0]  pos_q;
  logic [ADDR_W-1:0] dst_q;
  logic [LEN_W-1:0]  cnt_q;   // Remaining words
  logic [LEN_W-1:0]  off_q;   // Word offset into destination
  logic              wr_active;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
    end else if (job_en_i) begin
      busy_q <= 1'b1;
    end else if (done_en_o) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (job_en_i) begin
      pos_q <= job_pos_i;
      dst_q <= job_i.dst;
      cnt_q <= job_i.len;
      off_q <= '0;
    end else if (s2m_i.ack) begin
      cnt_q <= cnt_q - 1'b1;
      off_q <= off_q + 1'b1;
    end
  end

  // Release the bus whenever the FIFO runs dry
  assign wr_active  = busy_q && (cnt_q != '0) && !fifo_empty_i;
  assign done_en_o  = busy_q && (cnt_q == '0);  // Zero length finishes at once
  assign done_pos_o = pos_q;
  assign busy_o     = busy_q;
  assign pop_o      = s2m_i.ack;

  always_comb begin
    m2s_o     = '0;
    m2s_o.adr = dst_q + ADDR_W'({off_q, 2'b00});
    m2s_o.dat = pop_data_i;  // FIFO head
    m2s_o.sel = '1;
    m2s_o.we  = 1'b1;
    m2s_o.cyc = wr_active;
    m2s_o.stb = wr_active;
  end

endmodule

`default_nettype wire

// ==== dma/dma_reader.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_reader (
  input  wire                          clk,
  input  wire                          rst,
  input  wire  [dma_pkg::ENTRIES-1:0]  pending_i,
  output logic [dma_pkg::POS_W-1:0]    sel_pos_o,
  input  wire  dma_pkg::dma_req_t      sel_req_i,
  output logic                         claim_en_o,
  input  wire                          writer_busy_i,
  output logic                         job_en_o,
  output dma_pkg::dma_req_t            job_o,
  output logic [dma_pkg::POS_W-1:0]    job_pos_o,
  input  wire                          fifo_full_i,
  output logic                         push_o,
  output logic [dma_pkg::DATA_W-1:0]   push_data_o,
  output dma_pkg::wb_m2s_t             m2s_o,
  input  wire  dma_pkg::wb_s2m_t       s2m_i
);

  import dma_pkg::*;

  typedef enum logic [1:0] {IDLE, CLAIM, JOB, READ} state_t;

  state_t            state_q;
  logic [POS_W-1:0]  pos_q;
  logic [POS_W-1:0]  lowest;
  dma_req_t          job_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  cnt_q;   // Words still to read
  logic              rd_active;

  // Lowest pending entry wins
  always_comb begin
    lowest = '0;
    for (int i = ENTRIES - 1; i >= 0; i--) begin
      if (pending_i[i]) lowest = POS_W'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (|pending_i && !writer_busy_i) state_q <= CLAIM;
        CLAIM:   state_q <= JOB;
        JOB:     state_q <= (cnt_q == '0) ? IDLE : READ;
        READ:    if (s2m_i.ack && cnt_q == LEN_W'(1)) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE) pos_q <= lowest;
    if (state_q == CLAIM) begin
      job_q  <= sel_req_i;
      addr_q <= sel_req_i.src;
      cnt_q  <= sel_req_i.len;
    end else if (s2m_i.ack) begin
      addr_q <= addr_q + ADDR_W'(4);  // Next word
      cnt_q  <= cnt_q - 1'b1;
    end
  end

  assign sel_pos_o  = pos_q;
  assign claim_en_o = (state_q == CLAIM);
  assign job_en_o   = (state_q == JOB);
  assign job_o      = job_q;
  assign job_pos_o  = pos_q;

  // Cycle dropped while FIFO full so the writer can take the bus
  assign rd_active   = (state_q == READ) && !fifo_full_i;
  assign push_o      = s2m_i.ack;
  assign push_data_o = s2m_i.dat;

  always_comb begin
    m2s_o     = '0;
    m2s_o.adr = addr_q;
    m2s_o.sel = '1;
    m2s_o.cyc = rd_active;
    m2s_o.stb = rd_active;
  end

endmodule

`default_nettype wire

// ==== dma/dma_request_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_request_table (
  input  wire                          clk,
  input  wire                          rst,
  // Field writes and commands from the configuration slave
  input  wire                          wr_en_i,
  input  wire  [dma_pkg::POS_W-1:0]    wr_pos_i,
  input  wire  [1:0]                   wr_sel_i,
  input  wire  [dma_pkg::DATA_W-1:0]   wr_data_i,
  input  wire                          go_en_i,
  input  wire  [dma_pkg::POS_W-1:0]    go_pos_i,
  input  wire                          ack_en_i,
  input  wire  [dma_pkg::POS_W-1:0]    ack_pos_i,
  input  wire  [dma_pkg::POS_W-1:0]    rd_pos_i,
  output dma_pkg::dma_req_t            rd_req_o,
  output logic [2:0]                   rd_state_o,
  // Reader side
  input  wire  [dma_pkg::POS_W-1:0]    sel_pos_i,
  output dma_pkg::dma_req_t            sel_req_o,
  output logic [dma_pkg::ENTRIES-1:0]  pending_o,
  input  wire                          claim_en_i,
  // Writer completion
  input  wire                          done_en_i,
  input  wire  [dma_pkg::POS_W-1:0]    done_pos_i,
  output logic [dma_pkg::ENTRIES-1:0]  irq_o
);

  import dma_pkg::*;

  dma_req_t           req_q [ENTRIES];
  logic [ENTRIES-1:0] valid_q;
  logic [ENTRIES-1:0] busy_q;
  logic [ENTRIES-1:0] done_q;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      case (wr_sel_i)
        REG_SRC: req_q[wr_pos_i].src <= wr_data_i;
        REG_DST: req_q[wr_pos_i].dst <= wr_data_i;
        REG_LEN: req_q[wr_pos_i].len <= wr_data_i[LEN_W-1:0];
        default: ;
      endcase
    end
  end

  // Entry life cycle: go -> claimed (busy) -> done
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      busy_q  <= '0;
      done_q  <= '0;
    end else begin
      if (go_en_i) begin
        valid_q[go_pos_i] <= 1'b1;
        done_q[go_pos_i]  <= 1'b0;  // Re-arm clears a stale done
      end
      if (ack_en_i) done_q[ack_pos_i] <= 1'b0;
      if (claim_en_i) busy_q[sel_pos_i] <= 1'b1;
      if (done_en_i) begin
        valid_q[done_pos_i] <= 1'b0;
        busy_q[done_pos_i]  <= 1'b0;
        done_q[done_pos_i]  <= 1'b1;
      end
    end
  end

  assign rd_req_o   = req_q[rd_pos_i];
  assign rd_state_o = {busy_q[rd_pos_i], done_q[rd_pos_i], valid_q[rd_pos_i]};
  assign sel_req_o  = req_q[sel_pos_i];
  assign pending_o  = valid_q & ~busy_q;
  assign irq_o      = done_q;  // Held until software acks

endmodule

`default_nettype wire

// ==== dma/dma_cfg_wb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_cfg_wb (
  input  wire                          clk,
  input  wire                          rst,
  input  wire  dma_pkg::wb_m2s_t       cfg_m2s_i,
  output dma_pkg::wb_s2m_t             cfg_s2m_o,
  output logic                         wr_en_o,
  output logic [dma_pkg::POS_W-1:0]    wr_pos_o,
  output logic [1:0]                   wr_sel_o,
  output logic [dma_pkg::DATA_W-1:0]   wr_data_o,
  output logic                         go_en_o,
  output logic [dma_pkg::POS_W-1:0]    go_pos_o,
  output logic                         ack_en_o,
  output logic [dma_pkg::POS_W-1:0]    ack_pos_o,
  input  wire  dma_pkg::dma_req_t      rd_req_i,
  input  wire  [2:0]                   rd_state_i  // {busy, done, valid}
);

  import dma_pkg::*;

  logic             ack_q;
  logic [POS_W-1:0] entry;
  logic [1:0]       word;
  logic             wr_cycle;
  logic             ctrl_wr;

  assign entry = cfg_m2s_i.adr[5:4];
  assign word  = cfg_m2s_i.adr[3:2];

  // One wait state, then a single-cycle ack
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= cfg_m2s_i.cyc & cfg_m2s_i.stb & ~ack_q;
    end
  end

  // Commands fire in the ack cycle, table updates on the closing edge
  assign wr_cycle = ack_q & cfg_m2s_i.cyc & cfg_m2s_i.stb & cfg_m2s_i.we;
  assign ctrl_wr  = wr_cycle & (word == REG_CTRL);

  assign wr_en_o   = wr_cycle & (word != REG_CTRL);
  assign wr_pos_o  = entry;
  assign wr_sel_o  = word;
  assign wr_data_o = cfg_m2s_i.dat;

  assign go_en_o   = ctrl_wr & cfg_m2s_i.dat[CTRL_GO_BIT];
  assign go_pos_o  = entry;
  assign ack_en_o  = ctrl_wr & cfg_m2s_i.dat[CTRL_ACK_BIT];
  assign ack_pos_o = entry;

  // Read data follows the address, qualified by ack
  always_comb begin
    cfg_s2m_o.ack = ack_q;
    case (word)
      REG_SRC: cfg_s2m_o.dat = rd_req_i.src;
      REG_DST: cfg_s2m_o.dat = rd_req_i.dst;
      REG_LEN: cfg_s2m_o.dat = DATA_W'(rd_req_i.len);
      default: cfg_s2m_o.dat = DATA_W'(rd_state_i);
    endcase
  end

endmodule

`default_nettype wire

// ==== src/dma_word_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module dma_word_fifo (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          push_i,
  input  wire  [dma_pkg::DATA_W-1:0]   push_data_i,
  input  wire                          pop_i,
  output logic [dma_pkg::DATA_W-1:0]   pop_data_o,
  output logic                         full_o,
  output logic                         empty_o
);

  import dma_pkg::*;

  logic [DATA_W-1:0]               mem_q [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr_q;  // Wraps, depth is a power of two
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(FIFO_DEPTH):0]     count_q;
  logic                            do_push;
  logic                            do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;  // Both or neither
      endcase
    end
  end

  assign pop_data_o = mem_q[rd_ptr_q];
  assign full_o     = (count_q == FIFO_DEPTH);
  assign empty_o    = (count_q == '0);

endmodule

`default_nettype wire

// ==== common/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes

  localparam int ADDR_W     = 32;  // Byte address
  localparam int DATA_W     = 32;
  localparam int LEN_W      = 16;  // Transfer length in words
  localparam int ENTRIES    = 4;
  localparam int POS_W      = 2;
  localparam int FIFO_DEPTH = 4;

  // Word offsets within one entry, entry itself in adr[5:4]
  localparam logic [1:0] REG_SRC  = 2'd0;
  localparam logic [1:0] REG_DST  = 2'd1;
  localparam logic [1:0] REG_LEN  = 2'd2;
  localparam logic [1:0] REG_CTRL = 2'd3;

  // Control write fields
  localparam int CTRL_GO_BIT  = 0;
  localparam int CTRL_ACK_BIT = 1;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles

  typedef struct packed {
    logic [ADDR_W-1:0] src;
    logic [ADDR_W-1:0] dst;
    logic [LEN_W-1:0]  len;
  } dma_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0]   adr;
    logic [DATA_W-1:0]   dat;
    logic [DATA_W/8-1:0] sel;
    logic                we;
    logic                cyc;
    logic                stb;
  } wb_m2s_t;

  typedef struct packed {
    logic [DATA_W-1:0] dat;
    logic              ack;
  } wb_s2m_t;

endpackage

`default_nettype wire
